//--- sources.f
src/sssp_task_pkg.sv
src/sssp_reg_pkg.sv
src/task_fifo.sv
src/sssp_rw.sv
src/sssp_worker.sv
src/mem_read_unit.sv
src/sssp_tile.sv
bench/graph_mem.sv
bench/tb_sssp_tile.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_sssp_tile
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_sssp_tile.sv
`timescale 1ns/1ps

module tb_sssp_tile;
   import sssp_task_pkg::*;
   import sssp_reg_pkg::*;

   localparam int          NV         = 24;
   localparam int          MAX_EDGES  = NV * 6;
   localparam int          IDLE_LIMIT = 200;
   localparam int          RUN_LIMIT  = 200000;
   localparam int unsigned INF        = 32'hFFFF_FFFF;

   logic                  clk;
   logic                  rstn;
   logic                  task_in_valid;
   logic                  task_in_ready;
   logic [31:0]           task_in_ts;
   logic [31:0]           task_in_locale;
   logic                  child_valid;
   logic                  child_ready;
   logic [31:0]           child_ts;
   logic [31:0]           child_locale;
   logic                  arvalid;
   logic                  arready;
   logic [31:0]           araddr;
   logic [7:0]            arlen;
   logic [2:0]            arsize;
   logic                  rvalid;
   logic                  rready;
   logic [63:0]           rdata;
   logic                  rlast;
   logic                  wvalid;
   logic [31:0]           waddr;
   logic [63:0]           wdata;
   logic                  reg_wvalid;
   logic [REG_ADDR_W-1:0] reg_waddr;
   logic [REG_DATA_W-1:0] reg_wdata;
   logic                  load_valid;
   logic [31:0]           load_addr;
   logic [31:0]           load_data;
   logic                  root_req;
   logic [31:0]           root_locale;

   int          deg [NV];
   int          offs [NV+1];
   int          edge_dst [MAX_EDGES];
   int          edge_wt [MAX_EDGES];
   int          burst_len [MAX_EDGES];   // Degree of the vertex whose list starts at this entry
   bit          is_target [NV];
   int unsigned ref_dist [NV];
   int          num_edges;
   int          rw_base_w;
   int          off_base_w;
   int          nb_base_w;
   task_t       pending [$];
   int          fed [logic [63:0]];   // Count of tasks handed to the tile per {ts, locale}
   logic [63:0] in_key;
   logic [63:0] wr_key;
   int          child_count;
   int          exp_children;
   int          idle_cycles;

   sssp_tile UUT (.*);

   graph_mem u_mem (
      .clk, .rstn, .arvalid, .arready, .araddr, .arlen, .arsize, .rvalid, .rready, .rdata,
      .rlast, .wvalid, .waddr, .wdata, .load_valid, .load_addr, .load_data
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_mismatch(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      $display("** FAIL **");
      $fatal(1, "stopped at the first failed check");
   endtask

   task automatic abort_timeout(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "stopped on a timeout");
   endtask

   function automatic bit read_ok(input logic [31:0] addr, input logic [7:0] len,
                                  input logic [2:0] size);
      int w;
      int rel;
      w = int'(addr[31:2]);
      if (addr[1:0] != 2'b00) return 1'b0;
      if (w >= rw_base_w && w < rw_base_w + NV) return (len == 8'd0 && size == 3'd2);
      if (w >= off_base_w && w < off_base_w + NV) return (len == 8'd0 && size == 3'd3);
      rel = w - nb_base_w;
      if (rel < 0 || rel >= 2 * num_edges || rel % 2 != 0) return 1'b0;
      return (size == 3'd3 && burst_len[rel / 2] == int'(len) + 1);
   endfunction

   function automatic bit child_ok(input logic [31:0] ts, input logic [31:0] locale);
      if (locale >= 32'(NV)) return 1'b0;
      return is_target[locale] && ts >= ref_dist[locale];
   endfunction

   function automatic int written_degree(input logic [31:0] addr);
      int v;
      v = int'(addr[31:2]) - rw_base_w;
      if (v < 0 || v >= NV) return 0;
      return deg[v];
   endfunction

   function automatic void build_graph();
      int v;
      int k;
      int e;
      e = 0;
      for (v = 0; v < NV; v++) begin
         deg[v]  = $urandom_range(6, 0);
         offs[v] = e;
         for (k = 0; k < deg[v]; k++) begin
            edge_dst[e]            = $urandom_range(NV - 1, 0);
            edge_wt[e]             = $urandom_range(50, 1);
            is_target[edge_dst[e]] = 1'b1;
            e++;
         end
      end
      offs[NV]  = e;
      num_edges = e;
      for (v = 0; v < NV; v++) begin
         if (deg[v] != 0) burst_len[offs[v]] = deg[v];
      end
   endfunction

   // Plain O(V^2) Dijkstra over the generated graph
   function automatic void compute_reference(input int root);
      bit done [NV];
      int u;
      int v;
      int e;
      for (v = 0; v < NV; v++) begin
         ref_dist[v] = INF;
         done[v]     = 1'b0;
      end
      ref_dist[root] = 0;
      repeat (NV) begin
         u = -1;
         for (v = 0; v < NV; v++) begin
            if (!done[v] && ref_dist[v] != INF && (u < 0 || ref_dist[v] < ref_dist[u])) u = v;
         end
         if (u >= 0) begin
            done[u] = 1'b1;
            for (e = offs[u]; e < offs[u + 1]; e++) begin
               if (ref_dist[u] + edge_wt[e] < ref_dist[edge_dst[e]]) begin
                  ref_dist[edge_dst[e]] = ref_dist[u] + edge_wt[e];
               end
            end
         end
      end
   endfunction

   task automatic load_word(input int addr, input int data);
      @(posedge clk);
      load_valid <= 1'b1;
      load_addr  <= 32'(addr);
      load_data  <= 32'(data);
   endtask

   task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input int data);
      @(posedge clk);
      reg_wvalid <= 1'b1;
      reg_waddr  <= addr;
      reg_wdata  <= 32'(data);
   endtask

   task automatic run_sssp(input int rw_w, input int off_w, input int nb_w, input int root);
      int v;
      int e;
      int cycles;
      @(posedge clk);
      rstn       <= 1'b0;
      rw_base_w  <= rw_w;
      off_base_w <= off_w;
      nb_base_w  <= nb_w;
      compute_reference(root);
      repeat (3) @(posedge clk);
      reset_check: assert (task_in_ready && !arvalid && !wvalid && !child_valid && !rready)
         else report_mismatch("tile outputs are not at their reset values");
      rstn <= 1'b1;
      for (v = 0; v < NV; v++) load_word(rw_w + v, INF);
      for (v = 0; v <= NV; v++) load_word(off_w + v, offs[v]);
      for (e = 0; e < num_edges; e++) begin
         load_word(nb_w + 2 * e, edge_dst[e]);
         load_word(nb_w + 2 * e + 1, edge_wt[e]);
      end
      @(posedge clk);
      load_valid <= 1'b0;
      write_reg(RW_BASE_ADDR, rw_w);
      write_reg(OFFSET_BASE_ADDR, off_w);
      write_reg(NEIGHBOR_BASE_ADDR, nb_w);
      @(posedge clk);
      reg_wvalid  <= 1'b0;
      root_locale <= 32'(root);
      root_req    <= 1'b1;
      @(posedge clk);
      root_req <= 1'b0;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > RUN_LIMIT) abort_timeout("timeout: the tile never went idle");
      end while (idle_cycles < IDLE_LIMIT);
      for (v = 0; v < NV; v++) begin
         dist_check: assert (u_mem.mem[rw_w + v] == ref_dist[v])
            else report_mismatch($sformatf("vertex %0d distance %0d, expected %0d",
                                           v, u_mem.mem[rw_w + v], ref_dist[v]));
      end
      count_check: assert (child_count == exp_children)
         else report_mismatch($sformatf("%0d children seen, expected %0d",
                                        child_count, exp_children));
   endtask

   write_smaller_check: assert property (@(posedge clk) disable iff (!rstn)
      wvalid |-> wdata[31:0] < u_mem.mem[waddr[11:2]])
      else report_mismatch("distance write does not lower the stored value");

   child_check: assert property (@(posedge clk) disable iff (!rstn)
      child_valid |-> child_ok(child_ts, child_locale))
      else report_mismatch("child has an unknown locale or a ts below the shortest path");

   read_check: assert property (@(posedge clk) disable iff (!rstn)
      arvalid |-> read_ok(araddr, arlen, arsize))
      else report_mismatch("read request outside the graph arrays or with a wrong length");

   rready_check: assert property (@(posedge clk) disable iff (!rstn)
      rvalid |-> rready)
      else report_mismatch("read beat offered while rready is low");

   // Every child comes back from the scheduler as a new task
   always @(posedge clk) begin
      if (!rstn) begin
         pending.delete();
         fed.delete();
         task_in_valid <= 1'b0;
         child_ready   <= 1'b0;
         child_count   = 0;
         exp_children  = 0;
         idle_cycles   <= 0;
      end else begin
         if (task_in_valid && task_in_ready) begin
            in_key      = {task_in_ts, task_in_locale};
            fed[in_key] = fed.exists(in_key) ? fed[in_key] + 1 : 1;
            void'(pending.pop_front());
         end
         if (child_valid && child_ready) begin
            pending.push_back('{ts: child_ts, locale: child_locale});
            child_count++;
         end
         if (wvalid) begin
            wr_key = {wdata[31:0], 32'(waddr[31:2]) - 32'(rw_base_w)};
            write_check: assert (waddr[1:0] == 2'b00 && wdata[63:32] == 32'd0 &&
                                 fed.exists(wr_key) && fed[wr_key] > 0)
               else report_mismatch($sformatf("write of %0d to address %0h matches no task",
                                              wdata, waddr));
            fed[wr_key]  = fed[wr_key] - 1;
            exp_children += written_degree(waddr);
         end
         if (root_req) pending.push_back('{ts: 32'd0, locale: root_locale});
         task_in_valid <= (pending.size() != 0);
         if (pending.size() != 0) begin
            task_in_ts     <= pending[0].ts;
            task_in_locale <= pending[0].locale;
         end
         child_ready <= ($urandom_range(3, 0) != 0);   // Low about a quarter of the time
         if (root_req || pending.size() != 0 || task_in_valid || child_valid || arvalid ||
             rready || wvalid) begin
            idle_cycles <= 0;
         end else begin
            idle_cycles <= idle_cycles + 1;
         end
      end
   end

   initial begin
      void'($urandom(38));
      rstn           = 1'b0;
      task_in_valid  = 1'b0;
      task_in_ts     = '0;
      task_in_locale = '0;
      child_ready    = 1'b0;
      reg_wvalid     = 1'b0;
      reg_waddr      = '0;
      reg_wdata      = '0;
      load_valid     = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      root_req       = 1'b0;
      root_locale    = '0;
      build_graph();
      run_sssp(16, 48, 96, 0);
      run_sssp(400, 440, 480, 7);   // Relocated arrays and a new root
      $display("** PASS **");
      $finish;
   end

endmodule

//--- bench/graph_mem.sv
`timescale 1ns/1ps

module graph_mem #(
   parameter int WORDS = 1024
) (
   input  logic        clk,
   input  logic        rstn,
   input  logic        arvalid,
   output logic        arready,
   input  logic [31:0] araddr,
   input  logic [7:0]  arlen,
   input  logic [2:0]  arsize,
   output logic        rvalid,
   input  logic        rready,
   output logic [63:0] rdata,
   output logic        rlast,
   input  logic        wvalid,
   input  logic [31:0] waddr,
   input  logic [63:0] wdata,
   input  logic        load_valid,
   input  logic [31:0] load_addr,
   input  logic [31:0] load_data
);
   localparam int ADDR_W = $clog2(WORDS);

   logic [31:0]       mem [WORDS];   // One 32-bit word per entry, byte address over four
   logic [ADDR_W-1:0] cur_word;
   logic [7:0]        beats_left;
   logic              wide;
   logic              busy;
   int                gap;

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hC0DE_0000 ^ i;
      end
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
      rdata   = '0;
   end

   always @(posedge clk) begin
      if (load_valid) begin
         mem[load_addr[ADDR_W-1:0]] <= load_data;
      end
      if (wvalid) begin
         mem[waddr[ADDR_W+1:2]] <= wdata[31:0];
      end
      if (!rstn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rlast   <= 1'b0;
         busy    <= 1'b0;
      end else if (!busy) begin
         arready <= 1'b1;
         if (arvalid && arready) begin
            arready    <= 1'b0;
            busy       <= 1'b1;
            cur_word   <= araddr[ADDR_W+1:2];
            wide       <= (arsize == 3'd3);
            beats_left <= arlen;
            gap        <= $urandom_range(5, 0);   // First beat latency
         end
      end else if (rvalid) begin
         if (rready) begin
            rvalid <= 1'b0;
            if (rlast) begin
               busy <= 1'b0;
            end else begin
               cur_word   <= cur_word + ADDR_W'(2);
               beats_left <= beats_left - 8'd1;
               gap        <= $urandom_range(2, 0);
            end
         end
      end else if (gap != 0) begin
         gap <= gap - 1;
      end else begin
         rvalid <= 1'b1;
         rdata  <= wide ? {mem[cur_word + ADDR_W'(1)], mem[cur_word]} : {32'd0, mem[cur_word]};
         rlast  <= (beats_left == 8'd0);
      end
   end

endmodule

//--- src/sssp_tile.sv
`timescale 1ns/1ps

module sssp_tile (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                task_in_valid,
   output logic                                task_in_ready,
   input  logic [31:0]                         task_in_ts,
   input  logic [31:0]                         task_in_locale,
   output logic                                child_valid,
   input  logic                                child_ready,
   output logic [31:0]                         child_ts,
   output logic [31:0]                         child_locale,
   output logic                                arvalid,
   input  logic                                arready,
   output logic [31:0]                         araddr,
   output logic [7:0]                          arlen,
   output logic [2:0]                          arsize,
   input  logic                                rvalid,
   output logic                                rready,
   input  logic [63:0]                         rdata,
   input  logic                                rlast,
   output logic                                wvalid,
   output logic [31:0]                         waddr,
   output logic [63:0]                         wdata,
   input  logic                                reg_wvalid,
   input  logic [sssp_reg_pkg::REG_ADDR_W-1:0] reg_waddr,
   input  logic [sssp_reg_pkg::REG_DATA_W-1:0] reg_wdata
);
   import sssp_task_pkg::*;

   task_t                new_head;
   logic                 new_empty;
   logic                 new_full;
   work_item_t           rw_head;
   work_item_t           off_head;
   work_item_t           nb_head;
   work_item_t           ch_head;
   logic                 rw_empty;
   logic                 off_empty;
   logic                 off_full;
   logic                 nb_empty;
   logic                 ch_empty;
   logic [FREE_W-1:0]    free_rw;
   logic [FREE_W-1:0]    free_nb;
   logic [CH_FREE_W-1:0] free_ch;
   logic                 rw_pop;
   logic                 off_pop;
   logic                 nb_pop;
   logic                 ch_pop;
   logic                 rw_out_valid;
   task_t                rw_out_task;
   logic                 fetch_grant;
   logic                 w0_valid;
   logic                 w1_valid;
   logic                 w0_grant;
   logic                 w1_grant;
   logic [31:0]          w0_addr;
   logic [31:0]          w1_addr;
   logic [7:0]           w0_len;
   logic [7:0]           w1_len;
   logic [2:0]           w0_size;
   logic [2:0]           w1_size;
   task_t                w0_task;
   task_t                w1_task;
   subtype_t             w0_subtype;
   subtype_t             w1_subtype;
   logic                 push_rw;
   logic                 push_nb;
   logic                 push_ch;
   work_item_t           resp_item;

   assign task_in_ready = ~new_full;

   task_fifo #(.item_t(task_t), .DEPTH(QUEUE_DEPTH)) q_new (
      .clk, .rstn, .push(task_in_valid & task_in_ready), .push_item({task_in_ts, task_in_locale}),
      .pop(fetch_grant), .head(new_head), .empty(new_empty), .full(new_full), .free()
   );

   task_fifo #(.item_t(work_item_t), .DEPTH(QUEUE_DEPTH)) q_rw (
      .clk, .rstn, .push(push_rw), .push_item(resp_item), .pop(rw_pop),
      .head(rw_head), .empty(rw_empty), .full(), .free(free_rw)
   );

   task_fifo #(.item_t(work_item_t), .DEPTH(QUEUE_DEPTH)) q_off (
      .clk, .rstn, .push(rw_out_valid), .push_item({rw_out_task, 64'd0}), .pop(off_pop),
      .head(off_head), .empty(off_empty), .full(off_full), .free()
   );

   task_fifo #(.item_t(work_item_t), .DEPTH(QUEUE_DEPTH)) q_nb (
      .clk, .rstn, .push(push_nb), .push_item(resp_item), .pop(nb_pop),
      .head(nb_head), .empty(nb_empty), .full(), .free(free_nb)
   );

   task_fifo #(.item_t(work_item_t), .DEPTH(MAX_BURST)) q_ch (
      .clk, .rstn, .push(push_ch), .push_item(resp_item), .pop(ch_pop),
      .head(ch_head), .empty(ch_empty), .full(), .free(free_ch)
   );

   sssp_rw u_rw (
      .clk, .rstn, .task_in_valid(~rw_empty), .task_in_ready(rw_pop),
      .in_task(rw_head.tsk), .in_data(rw_head.data), .wvalid, .waddr, .wdata,
      .out_valid(rw_out_valid), .out_task(rw_out_task), .sched_task_valid(),
      .sched_task_ready(~off_full), .reg_wvalid, .reg_waddr, .reg_wdata
   );

   sssp_worker #(.SUBTYPE(0)) u_offset (
      .clk, .rstn, .task_in_valid(~off_empty), .task_in_ready(off_pop),
      .in_task(off_head.tsk), .in_data(off_head.data), .req_valid(), .req_addr(w0_addr),
      .req_len(w0_len), .req_size(w0_size), .resp_task(w0_task), .resp_subtype(w0_subtype),
      .out_valid(), .out_task(), .sched_task_valid(w0_valid), .sched_task_ready(w0_grant),
      .reg_wvalid, .reg_waddr, .reg_wdata
   );

   sssp_worker #(.SUBTYPE(1)) u_neighbor (
      .clk, .rstn, .task_in_valid(~nb_empty), .task_in_ready(nb_pop),
      .in_task(nb_head.tsk), .in_data(nb_head.data), .req_valid(), .req_addr(w1_addr),
      .req_len(w1_len), .req_size(w1_size), .resp_task(w1_task), .resp_subtype(w1_subtype),
      .out_valid(), .out_task(), .sched_task_valid(w1_valid), .sched_task_ready(w1_grant),
      .reg_wvalid, .reg_waddr, .reg_wdata
   );

   sssp_worker #(.SUBTYPE(2)) u_child (
      .clk, .rstn, .task_in_valid(~ch_empty), .task_in_ready(ch_pop),
      .in_task(ch_head.tsk), .in_data(ch_head.data), .req_valid(), .req_addr(),
      .req_len(), .req_size(), .resp_task(), .resp_subtype(),
      .out_valid(child_valid), .out_task({child_ts, child_locale}), .sched_task_valid(),
      .sched_task_ready(child_ready), .reg_wvalid, .reg_waddr, .reg_wdata
   );

   mem_read_unit u_read (
      .clk, .rstn,
      .fetch_valid(~new_empty), .fetch_task(new_head), .fetch_grant,
      .w0_valid, .w0_addr, .w0_len, .w0_size, .w0_task, .w0_subtype, .w0_grant,
      .w1_valid, .w1_addr, .w1_len, .w1_size, .w1_task, .w1_subtype, .w1_grant,
      .arvalid, .arready, .araddr, .arlen, .arsize, .rvalid, .rready, .rdata, .rlast,
      .free_rw, .free_nb, .free_ch,
      .resp_push_rw(push_rw), .resp_push_nb(push_nb), .resp_push_ch(push_ch), .resp_item,
      .reg_wvalid, .reg_waddr, .reg_wdata
   );

endmodule

//--- src/mem_read_unit.sv
`timescale 1ns/1ps

module mem_read_unit (
   input  logic                                   clk,
   input  logic                                   rstn,
   input  logic                                   fetch_valid,
   input  sssp_task_pkg::task_t                   fetch_task,
   output logic                                   fetch_grant,
   input  logic                                   w0_valid,
   input  logic [31:0]                            w0_addr,
   input  logic [7:0]                             w0_len,
   input  logic [2:0]                             w0_size,
   input  sssp_task_pkg::task_t                   w0_task,
   input  sssp_task_pkg::subtype_t                w0_subtype,
   output logic                                   w0_grant,
   input  logic                                   w1_valid,
   input  logic [31:0]                            w1_addr,
   input  logic [7:0]                             w1_len,
   input  logic [2:0]                             w1_size,
   input  sssp_task_pkg::task_t                   w1_task,
   input  sssp_task_pkg::subtype_t                w1_subtype,
   output logic                                   w1_grant,
   output logic                                   arvalid,
   input  logic                                   arready,
   output logic [31:0]                            araddr,
   output logic [7:0]                             arlen,
   output logic [2:0]                             arsize,
   input  logic                                   rvalid,
   output logic                                   rready,
   input  sssp_task_pkg::data_t                   rdata,
   input  logic                                   rlast,
   input  logic [sssp_task_pkg::FREE_W-1:0]       free_rw,
   input  logic [sssp_task_pkg::FREE_W-1:0]       free_nb,
   input  logic [sssp_task_pkg::CH_FREE_W-1:0]    free_ch,
   output logic                                   resp_push_rw,
   output logic                                   resp_push_nb,
   output logic                                   resp_push_ch,
   output sssp_task_pkg::work_item_t              resp_item,
   input  logic                                   reg_wvalid,
   input  logic [sssp_reg_pkg::REG_ADDR_W-1:0]    reg_waddr,
   input  logic [sssp_reg_pkg::REG_DATA_W-1:0]    reg_wdata
);
   import sssp_task_pkg::*;
   import sssp_reg_pkg::*;

   logic        busy;
   logic [31:0] rw_base;
   task_t       cur_task;
   subtype_t    cur_subtype;
   logic        w1_ok;
   logic        w0_ok;
   logic        fetch_ok;
   logic        start;
   logic        beat;

   // A request goes out only when its queue can take the whole burst
   assign w1_ok    = w1_valid & ((w1_subtype == ST_NONE) | (9'(free_ch) > 9'(w1_len)));
   assign w0_ok    = w0_valid & (free_nb != '0);
   // Fetch waits for an empty q_rw so every pending distance write lands before the next read
   assign fetch_ok = fetch_valid & (free_rw == FREE_W'(QUEUE_DEPTH));

   assign w1_grant    = ~busy & w1_ok;
   assign w0_grant    = ~busy & ~w1_ok & w0_ok;
   assign fetch_grant = ~busy & ~w1_ok & ~w0_ok & fetch_ok;
   assign start       = (w1_grant & (w1_subtype != ST_NONE)) | w0_grant | fetch_grant;

   assign rready       = busy;
   assign beat         = rvalid & rready;
   assign resp_item    = '{tsk: cur_task, data: rdata};
   assign resp_push_rw = beat & (cur_subtype == ST_RW);
   assign resp_push_nb = beat & (cur_subtype == ST_NEIGHBOR);
   assign resp_push_ch = beat & (cur_subtype == ST_CHILD);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy    <= 1'b0;
         arvalid <= 1'b0;
         rw_base <= '0;
      end else begin
         if (reg_wvalid && reg_waddr == RW_BASE_ADDR) begin
            rw_base <= {reg_wdata[REG_DATA_W-3:0], 2'b00};
         end
         if (arvalid && arready) begin
            arvalid <= 1'b0;
         end
         if (beat && rlast) begin
            busy <= 1'b0;
         end
         if (start) begin
            busy    <= 1'b1;
            arvalid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (w1_grant) begin
         araddr      <= w1_addr;
         arlen       <= w1_len;
         arsize      <= w1_size;
         cur_task    <= w1_task;
         cur_subtype <= w1_subtype;
      end else if (w0_grant) begin
         araddr      <= w0_addr;
         arlen       <= w0_len;
         arsize      <= w0_size;
         cur_task    <= w0_task;
         cur_subtype <= w0_subtype;
      end else if (fetch_grant) begin
         araddr      <= rw_base + (fetch_task.locale << 2);
         arlen       <= 8'd0;
         arsize      <= 3'd2;
         cur_task    <= fetch_task;
         cur_subtype <= ST_RW;
      end
   end

endmodule

//--- src/sssp_worker.sv
`timescale 1ns/1ps

module sssp_worker #(
   parameter int SUBTYPE = 0
) (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                task_in_valid,
   output logic                                task_in_ready,
   input  sssp_task_pkg::task_t                in_task,
   input  sssp_task_pkg::data_t                in_data,
   output logic                                req_valid,
   output logic [31:0]                         req_addr,
   output logic [7:0]                          req_len,
   output logic [2:0]                          req_size,
   output sssp_task_pkg::task_t                resp_task,
   output sssp_task_pkg::subtype_t             resp_subtype,
   output logic                                out_valid,
   output sssp_task_pkg::task_t                out_task,
   output logic                                sched_task_valid,
   input  logic                                sched_task_ready,
   input  logic                                reg_wvalid,
   input  logic [sssp_reg_pkg::REG_ADDR_W-1:0] reg_waddr,
   input  logic [sssp_reg_pkg::REG_DATA_W-1:0] reg_wdata
);
   import sssp_task_pkg::*;
   import sssp_reg_pkg::*;

   logic [31:0] offset_base;
   logic [31:0] neighbor_base;
   logic [31:0] degree;

   assign sched_task_valid = task_in_valid;
   assign task_in_ready    = sched_task_ready;
   assign resp_task        = in_task;
   assign degree           = in_data[63:32] - in_data[31:0];

   always_comb begin
      req_valid    = 1'b0;
      req_addr     = '0;
      req_len      = '0;
      req_size     = 3'd3;
      resp_subtype = ST_NONE;
      out_valid    = 1'b0;
      out_task     = in_task;
      case (SUBTYPE)
         0: begin
            req_valid    = task_in_valid;
            req_addr     = offset_base + (in_task.locale << 2);   // Pair spans the next start
            resp_subtype = ST_NEIGHBOR;
         end
         1: begin
            req_valid    = task_in_valid & (degree != '0);
            req_addr     = neighbor_base + (in_data[31:0] << 3);
            req_len      = 8'(degree - 32'd1);
            resp_subtype = (degree != '0) ? ST_CHILD : ST_NONE;   // Read unit drops a leaf
         end
         default: begin
            out_valid       = task_in_valid;
            out_task.locale = in_data[31:0];
            out_task.ts     = in_task.ts + in_data[63:32];
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         offset_base   <= '0;
         neighbor_base <= '0;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            OFFSET_BASE_ADDR:   offset_base   <= {reg_wdata[REG_DATA_W-3:0], 2'b00};
            NEIGHBOR_BASE_ADDR: neighbor_base <= {reg_wdata[REG_DATA_W-3:0], 2'b00};
            default: ;
         endcase
      end
   end

endmodule

//--- src/sssp_rw.sv
`timescale 1ns/1ps

module sssp_rw (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic                                task_in_valid,
   output logic                                task_in_ready,
   input  sssp_task_pkg::task_t                in_task,
   input  sssp_task_pkg::data_t                in_data,
   output logic                                wvalid,
   output logic [31:0]                         waddr,
   output sssp_task_pkg::data_t                wdata,
   output logic                                out_valid,
   output sssp_task_pkg::task_t                out_task,
   output logic                                sched_task_valid,
   input  logic                                sched_task_ready,
   input  logic                                reg_wvalid,
   input  logic [sssp_reg_pkg::REG_ADDR_W-1:0] reg_waddr,
   input  logic [sssp_reg_pkg::REG_DATA_W-1:0] reg_wdata
);
   import sssp_reg_pkg::*;

   logic [31:0] rw_base;
   logic        improve;

   assign sched_task_valid = task_in_valid;
   assign task_in_ready    = task_in_valid & sched_task_ready;
   assign improve          = (in_data[31:0] > in_task.ts);

   assign wvalid    = task_in_ready & improve;   // A head stalled on q_off writes only once
   assign waddr     = rw_base + (in_task.locale << 2);
   assign wdata     = {32'd0, in_task.ts};
   assign out_valid = wvalid;
   assign out_task  = in_task;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rw_base <= '0;
      end else if (reg_wvalid && reg_waddr == RW_BASE_ADDR) begin
         rw_base <= {reg_wdata[REG_DATA_W-3:0], 2'b00};
      end
   end

endmodule

//--- src/task_fifo.sv
`timescale 1ns/1ps

module task_fifo #(
   parameter type item_t = logic [63:0],
   parameter int  DEPTH  = 16
) (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       push,
   input  item_t                      push_item,
   input  logic                       pop,
   output item_t                      head,
   output logic                       empty,
   output logic                       full,
   output logic [$clog2(DEPTH+1)-1:0] free
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;
   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(DEPTH));
   assign free    = CNT_W'(DEPTH) - count;
   assign head    = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_item;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

endmodule

//--- src/sssp_reg_pkg.sv
package sssp_reg_pkg;

   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 32;

   // All three hold word addresses
   localparam logic [REG_ADDR_W-1:0] RW_BASE_ADDR       = 8'd0;
   localparam logic [REG_ADDR_W-1:0] OFFSET_BASE_ADDR   = 8'd1;
   localparam logic [REG_ADDR_W-1:0] NEIGHBOR_BASE_ADDR = 8'd2;

endpackage

//--- src/sssp_task_pkg.sv
package sssp_task_pkg;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
   } task_t;

   // Offset pair is {end, start}, neighbor entry is {weight, id}, distance sits in the low word
   typedef logic [63:0] data_t;

   typedef enum logic [1:0] {
      ST_RW       = 2'd0,
      ST_NEIGHBOR = 2'd1,
      ST_CHILD    = 2'd2,
      ST_NONE     = 2'd3     // No response expected
   } subtype_t;

   typedef struct packed {
      task_t tsk;
      data_t data;
   } work_item_t;

   localparam int QUEUE_DEPTH = 16;
   localparam int MAX_BURST   = 16;     // Longest neighbor list, the child queue holds one whole burst
   localparam int FREE_W      = $clog2(QUEUE_DEPTH + 1);
   localparam int CH_FREE_W   = $clog2(MAX_BURST + 1);

endpackage
